// File: vlog.f
+incdir+include
source/ant_pkg.sv
source/dp_request_issuer.sv
source/ant_update_ctrl.sv
source/ant_draw_ctrl.sv
source/ant_step_top.sv
verification/datapath_model.sv
verification/ant_step_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module ant_step_tb -o ant_step_sim

output=$(./obj_dir/ant_step_sim)
echo "$output"

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
else
    exit 1
fi

// File: verification/ant_step_tb.sv
`include "ant_params.svh"

module ant_step_tb;
    timeunit 1ns;
    timeprecision 100ps;

    // Six update commands and eighteen draw-phase commands per step
    localparam int cmds_per_step    = 24;
    localparam int worst_cmd_cycles = 20;
    localparam int step_count       = 20;
    localparam int timeout_cycles   = cmds_per_step * worst_cmd_cycles * step_count + 2000;

    localparam int x_min = `ANT_SPRITE_W / 2;
    localparam int x_max = `ANT_SCREEN_W - `ANT_SPRITE_W / 2 - 1;
    localparam int y_min = `ANT_SPRITE_H / 2;
    localparam int y_max = `ANT_SCREEN_H - `ANT_SPRITE_H / 2 - 1;

    logic                            clock;
    logic                            resetn;
    logic                            start;
    logic [`ANT_MEM_ADDR_WIDTH-1:0]  id;
    ant_pkg::move_t                  move;
    logic                            finished_dp;
    logic [`ANT_RESULT_WIDTH-1:0]    result_dp;
    logic                            done;
    ant_pkg::dp_req_t                dp;

    int                              fixed_delay;
    logic                            load_en;
    logic [`ANT_MEM_ADDR_WIDTH+1:0]  load_addr;
    logic [`ANT_RESULT_WIDTH-1:0]    load_data;

    int cycle_count = 0;
    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;

    ant_step_top u_dut (
        .clock       (clock),
        .resetn      (resetn),
        .start       (start),
        .id          (id),
        .move        (move),
        .finished_dp (finished_dp),
        .result_dp   (result_dp),
        .done        (done),
        .dp          (dp)
    );

    datapath_model u_model (
        .clock       (clock),
        .resetn      (resetn),
        .dp          (dp),
        .fixed_delay (fixed_delay),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .finished_dp (finished_dp),
        .result_dp   (result_dp)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_value(string name, int got, int expected);
        assert (got == expected) else begin
            $display("error %s: got 0x%0h, expected 0x%0h", name, got, expected);
            error_count++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond) else begin
            $display("%s", what);
            error_count++;
        end
    endtask

    task automatic finish_test(string name, int errors_before);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed, %0d errors", name, error_count - errors_before);
        end
    endtask

    function automatic int moved_x(int x, ant_pkg::move_t mv);
        if (mv.left && x > x_min) return x - 1;
        if (mv.right && x < x_max) return x + 1;
        return x;
    endfunction

    function automatic int moved_y(int y, ant_pkg::move_t mv);
        if (mv.up && y > y_min) return y - 1;
        if (mv.down && y < y_max) return y + 1;
        return y;
    endfunction

    // Three back-to-back preload writes into the model memory
    task automatic load_ant(int ant_id, int x, int y, int fitness);
        @(posedge clock);
        load_en   <= 1'b1;
        load_addr <= {8'(ant_id), ant_pkg::field_x};
        load_data <= 16'(x);
        @(posedge clock);
        load_addr <= {8'(ant_id), ant_pkg::field_y};
        load_data <= 16'(y);
        @(posedge clock);
        load_addr <= {8'(ant_id), ant_pkg::field_fitness};
        load_data <= 16'(fitness);
        @(posedge clock);
        load_en <= 1'b0;
    endtask

    task automatic pulse_start(int ant_id, ant_pkg::move_t mv);
        @(posedge clock);
        start <= 1'b1;
        id    <= 8'(ant_id);
        move  <= mv;
        @(posedge clock);
        start <= 1'b0;
    endtask

    task automatic wait_done();
        @(posedge clock);
        while (done !== 1'b1) begin
            @(posedge clock);
        end
    endtask

    task automatic step_ant(int ant_id, int x, int y, int fitness, ant_pkg::move_t mv,
                            output int base);
        load_ant(ant_id, x, y, fitness);
        base = u_model.cmd_log.size();
        pulse_start(ant_id, mv);
        wait_done();
    endtask

    // Reads of x, y, fitness, then write-back of the moved position
    task automatic check_update_log(int base, int ant_id, int x, int y, int fitness,
                                    ant_pkg::move_t mv);
        ant_pkg::dp_instr_t c;
        int words [3];
        check_true(u_model.cmd_log.size() - base == cmds_per_step,
                   "step did not issue exactly 24 commands");
        if (u_model.cmd_log.size() < base + cmds_per_step) return;
        words[0] = moved_x(x, mv);
        words[1] = moved_y(y, mv);
        words[2] = fitness;
        for (int i = 0; i < 6; i++) begin
            c = u_model.cmd_log[base + i];
            check_value("dp.instr.opcode", int'(c.opcode),
                        (i < 3) ? int'(ant_pkg::mem_read) : int'(ant_pkg::mem_write));
            check_value("dp.instr.id", int'(c.id), ant_id);
            check_value("dp.instr.field", int'(c.field), i % 3);
            check_value("dp.instr.wdata", int'(c.wdata), (i < 3) ? 0 : words[i - 3]);
        end
    endtask

    // Reads of x and y, then sixteen pixels with dx fastest
    task automatic check_draw_log(int base, int ant_id, int new_x, int new_y);
        ant_pkg::dp_instr_t c;
        if (u_model.cmd_log.size() < base + cmds_per_step) return;
        for (int r = 0; r < 2; r++) begin
            c = u_model.cmd_log[base + 6 + r];
            check_value("dp.instr.opcode", int'(c.opcode), int'(ant_pkg::mem_read));
            check_value("dp.instr.id", int'(c.id), ant_id);
            check_value("dp.instr.field", int'(c.field), r);
        end
        for (int k = 0; k < 16; k++) begin
            c = u_model.cmd_log[base + 8 + k];
            check_value("dp.instr.opcode", int'(c.opcode), int'(ant_pkg::draw));
            check_value("dp.instr.plot", int'(c.plot), 1);
            check_value("dp.instr.colour", int'(c.colour), 6);
            check_value("dp.instr.px", int'(c.px), new_x - 1 + k % 4);
            check_value("dp.instr.py", int'(c.py), new_y - 1 + k / 4);
        end
    endtask

    task automatic test_reset();
        int errors_before;
        errors_before = error_count;
        check_value("done", int'(done), 1);
        check_value("dp.start", int'(dp.start), 0);
        check_true(dp.instr == '0, "dp.instr is not zero after reset");
        repeat (10) begin
            @(posedge clock);
            check_value("dp.start", int'(dp.start), 0);
        end
        check_true(u_model.cmd_log.size() == 0, "a command appeared before any start");
        finish_test("reset", errors_before);
    endtask

    task automatic test_order();
        int errors_before;
        int base;
        errors_before = error_count;
        step_ant(8'h3c, 80, 60, 8'ha5, ant_pkg::move_t'(4'b0110), base);
        check_update_log(base, 8'h3c, 80, 60, 8'ha5, ant_pkg::move_t'(4'b0110));
        finish_test("command order", errors_before);
    endtask

    task automatic test_moves();
        int errors_before;
        int base;
        int ant_id;
        int x;
        int y;
        int fitness;
        ant_pkg::move_t mv;
        errors_before = error_count;
        for (int n = 0; n < 13; n++) begin
            ant_id  = int'($urandom_range(255, 0));
            x       = int'($urandom_range(x_max, x_min));
            y       = int'($urandom_range(y_max, y_min));
            fitness = int'($urandom_range(255, 0));
            mv      = ant_pkg::move_t'(4'($urandom_range(15, 0)));
            // Last pass requests all four directions at once
            if (n == 12) mv = ant_pkg::move_t'(4'b1111);
            step_ant(ant_id, x, y, fitness, mv, base);
            check_update_log(base, ant_id, x, y, fitness, mv);
        end
        finish_test("moves", errors_before);
    endtask

    task automatic test_margins();
        int errors_before;
        int base;
        int xs [4] = '{2, 157, 80, 80};
        int ys [4] = '{60, 60, 2, 117};
        logic [3:0] mvs [4] = '{4'b1000, 4'b0100, 4'b0010, 4'b0001};
        errors_before = error_count;
        for (int n = 0; n < 4; n++) begin
            step_ant(n + 1, xs[n], ys[n], 8'h11 * n, ant_pkg::move_t'(mvs[n]), base);
            check_true(u_model.cmd_log.size() >= base + 6, "margin step issued too few commands");
            if (u_model.cmd_log.size() >= base + 6) begin
                check_value("dp.instr.wdata", int'(u_model.cmd_log[base + 3].wdata), xs[n]);
                check_value("dp.instr.wdata", int'(u_model.cmd_log[base + 4].wdata), ys[n]);
            end
        end
        finish_test("margins", errors_before);
    endtask

    task automatic test_draw();
        int errors_before;
        int base;
        errors_before = error_count;
        step_ant(8'h77, 20, 100, 8'h42, ant_pkg::move_t'(4'b0101), base);
        check_true(u_model.cmd_log.size() - base == cmds_per_step,
                   "step did not issue exactly 24 commands");
        check_draw_log(base, 8'h77, 21, 101);
        finish_test("draw", errors_before);
    endtask

    task automatic test_backpressure();
        int errors_before;
        int base;
        int log_size;
        errors_before = error_count;
        @(posedge clock);
        fixed_delay <= 12;
        load_ant(8'hc3, 140, 30, 8'h5a);
        base = u_model.cmd_log.size();
        pulse_start(8'hc3, ant_pkg::move_t'(4'b0101));
        repeat (30) @(posedge clock);
        // Second start lands in the middle of the update phase, for another ant
        check_value("done", int'(done), 0);
        start <= 1'b1;
        id    <= 8'h00;
        move  <= ant_pkg::move_t'(4'b1010);
        @(posedge clock);
        start <= 1'b0;
        wait_done();
        check_update_log(base, 8'hc3, 140, 30, 8'h5a, ant_pkg::move_t'(4'b0101));
        check_draw_log(base, 8'hc3, 141, 31);
        log_size = u_model.cmd_log.size();
        repeat (40) @(posedge clock);
        check_true(u_model.cmd_log.size() == log_size, "start while busy caused an extra step");
        check_value("done", int'(done), 1);
        check_true(u_model.strobe_errors == 0, "a start strobe did not last two cycles");
        check_true(u_model.instr_errors == 0, "dp.instr changed while a command was open");
        fixed_delay <= 0;
        finish_test("back-pressure", errors_before);
    endtask

    initial begin
        void'($urandom(32'hc5c85b9e));
        resetn      = 1'b0;
        start       = 1'b0;
        id          = '0;
        move        = '0;
        fixed_delay = 0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        repeat (4) @(posedge clock);
        resetn <= 1'b1;

        test_reset();
        test_order();
        test_moves();
        test_margins();
        test_draw();
        test_backpressure();

        $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verification/datapath_model.sv
`include "ant_params.svh"

module datapath_model (
    input  logic                            clock,
    input  logic                            resetn,
    input  ant_pkg::dp_req_t                dp,
    input  int                              fixed_delay,
    input  logic                            load_en,
    input  logic [`ANT_MEM_ADDR_WIDTH+1:0]  load_addr,
    input  logic [`ANT_RESULT_WIDTH-1:0]    load_data,
    output logic                            finished_dp,
    output logic [`ANT_RESULT_WIDTH-1:0]    result_dp
);
    timeunit 1ns;
    timeprecision 100ps;

    // Ant record words, addressed by {id, field}
    logic [`ANT_RESULT_WIDTH-1:0] mem [0:(1 << (`ANT_MEM_ADDR_WIDTH + 2)) - 1];

    // Every completed command, in completion order
    ant_pkg::dp_instr_t cmd_log [$];

    ant_pkg::dp_instr_t cmd_q;
    int                 start_len;
    int                 wait_left;
    int                 strobe_errors;
    int                 instr_errors;

    initial begin
        for (int a = 0; a < (1 << (`ANT_MEM_ADDR_WIDTH + 2)); a++) begin
            mem[a] = 16'(a * 40503) ^ 16'(a >> 5);
        end
    end

    always @(posedge clock) begin
        int   delay;
        logic finish_now;
        finish_now = 1'b0;
        finished_dp <= 1'b0;
        if (!resetn) begin
            start_len     <= 0;
            wait_left     <= 0;
            strobe_errors <= 0;
            instr_errors  <= 0;
            result_dp     <= '0;
        end else begin
            if (load_en) begin
                mem[load_addr] <= load_data;
            end
            if (dp.start) begin
                // First start cycle latches the command
                if (start_len == 0) begin
                    cmd_q <= dp.instr;
                end else if (dp.instr != cmd_q) begin
                    instr_errors <= instr_errors + 1;
                end
                start_len <= start_len + 1;
            end else if (start_len != 0) begin
                // Strobe has just fallen
                if (start_len != 2) begin
                    strobe_errors <= strobe_errors + 1;
                end
                if (dp.instr != cmd_q) begin
                    instr_errors <= instr_errors + 1;
                end
                start_len <= 0;
                delay = (fixed_delay > 0) ? fixed_delay : int'($urandom_range(4, 1));
                if (delay == 1) begin
                    finish_now = 1'b1;
                end else begin
                    wait_left <= delay - 1;
                end
            end else if (wait_left != 0) begin
                if (dp.instr != cmd_q) begin
                    instr_errors <= instr_errors + 1;
                end
                if (wait_left == 1) begin
                    finish_now = 1'b1;
                end
                wait_left <= wait_left - 1;
            end

            if (finish_now) begin
                finished_dp <= 1'b1;
                result_dp   <= '0;
                cmd_log.push_back(cmd_q);
                case (cmd_q.opcode)
                    ant_pkg::mem_read: begin
                        result_dp <= mem[{cmd_q.id, cmd_q.field}];
                    end
                    ant_pkg::mem_write: begin
                        mem[{cmd_q.id, cmd_q.field}] <= cmd_q.wdata;
                    end
                    default: begin
                        // Draw commands are only logged
                    end
                endcase
            end
        end
    end

endmodule

// File: source/ant_step_top.sv
`include "ant_params.svh"

module ant_step_top (
    input  logic                            clock,
    input  logic                            resetn,
    input  logic                            start,
    input  logic [`ANT_MEM_ADDR_WIDTH-1:0]  id,
    input  ant_pkg::move_t                  move,
    input  logic                            finished_dp,
    input  logic [`ANT_RESULT_WIDTH-1:0]    result_dp,
    output logic                            done,
    output ant_pkg::dp_req_t                dp
);

    typedef enum logic [1:0] {
        ph_idle,
        ph_update,
        ph_draw
    } phase_t;

    phase_t                          phase;
    logic                            upd_go;
    logic                            draw_go;
    logic                            upd_phase_done;
    logic                            draw_phase_done;
    ant_pkg::dp_req_t                upd_dp;
    ant_pkg::dp_req_t                draw_dp;
    logic [`ANT_MEM_ADDR_WIDTH-1:0]  id_q;
    ant_pkg::move_t                  move_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            phase   <= ph_idle;
            done    <= 1'b1;
            upd_go  <= 1'b0;
            draw_go <= 1'b0;
        end else begin
            upd_go  <= 1'b0;
            draw_go <= 1'b0;
            case (phase)
                ph_idle: begin
                    // A start while busy is simply not seen here
                    if (start) begin
                        done   <= 1'b0;
                        upd_go <= 1'b1;
                        phase  <= ph_update;
                    end
                end
                ph_update: begin
                    if (upd_phase_done) begin
                        draw_go <= 1'b1;
                        phase   <= ph_draw;
                    end
                end
                ph_draw: begin
                    if (draw_phase_done) begin
                        done  <= 1'b1;
                        phase <= ph_idle;
                    end
                end
                default: begin
                    phase <= ph_idle;
                end
            endcase
        end
    end

    // Ant and direction are taken at start and held for the whole step
    always_ff @(posedge clock) begin
        if (phase == ph_idle && start) begin
            id_q   <= id;
            move_q <= move;
        end
    end

    ant_update_ctrl u_update (
        .clock       (clock),
        .resetn      (resetn),
        .go          (upd_go),
        .id          (id_q),
        .move        (move_q),
        .finished_dp (finished_dp && (phase == ph_update)),
        .result_dp   (result_dp),
        .dp          (upd_dp),
        .phase_done  (upd_phase_done)
    );

    ant_draw_ctrl u_draw (
        .clock       (clock),
        .resetn      (resetn),
        .go          (draw_go),
        .id          (id_q),
        .finished_dp (finished_dp && (phase == ph_draw)),
        .result_dp   (result_dp),
        .dp          (draw_dp),
        .phase_done  (draw_phase_done)
    );

    // Only the active phase owns the datapath port
    assign dp = (phase == ph_draw) ? draw_dp : upd_dp;

endmodule

// File: source/ant_draw_ctrl.sv
`include "ant_params.svh"

module ant_draw_ctrl (
    input  logic                            clock,
    input  logic                            resetn,
    input  logic                            go,
    input  logic [`ANT_MEM_ADDR_WIDTH-1:0]  id,
    input  logic                            finished_dp,
    input  logic [`ANT_RESULT_WIDTH-1:0]    result_dp,
    output ant_pkg::dp_req_t                dp,
    output logic                            phase_done
);

    localparam int dx_bits = $clog2(`ANT_SPRITE_W);
    localparam int dy_bits = $clog2(`ANT_SPRITE_H);
    localparam logic [dx_bits-1:0] dx_last = dx_bits'(`ANT_SPRITE_W - 1);
    localparam logic [dy_bits-1:0] dy_last = dy_bits'(`ANT_SPRITE_H - 1);

    typedef enum logic [1:0] {
        drw_idle,
        drw_load,
        drw_plot
    } drw_state_t;

    drw_state_t                      state;
    ant_pkg::ant_field_t             cur_field;
    logic                            issue;
    logic                            cmd_done;
    logic [`ANT_RESULT_WIDTH-1:0]    result;
    ant_pkg::dp_instr_t              instr;
    logic [dx_bits-1:0]              dx;
    logic [dy_bits-1:0]              dy;

    logic [`ANT_MEM_ADDR_WIDTH-1:0]  id_q;
    logic [`ANT_X_WIDTH-1:0]         org_x;
    logic [`ANT_Y_WIDTH-1:0]         org_y;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state      <= drw_idle;
            cur_field  <= ant_pkg::field_x;
            issue      <= 1'b0;
            phase_done <= 1'b0;
            dx         <= '0;
            dy         <= '0;
        end else begin
            issue      <= 1'b0;
            phase_done <= 1'b0;
            case (state)
                drw_idle: begin
                    if (go) begin
                        cur_field <= ant_pkg::field_x;
                        issue     <= 1'b1;
                        state     <= drw_load;
                    end
                end
                drw_load: begin
                    if (cmd_done) begin
                        if (cur_field == ant_pkg::field_x) begin
                            cur_field <= ant_pkg::field_y;
                        end else begin
                            dx    <= '0;
                            dy    <= '0;
                            state <= drw_plot;
                        end
                        issue <= 1'b1;
                    end
                end
                drw_plot: begin
                    // Raster order, dx fastest
                    if (cmd_done) begin
                        if (dx == dx_last) begin
                            dx <= '0;
                            if (dy == dy_last) begin
                                dy         <= '0;
                                phase_done <= 1'b1;
                                state      <= drw_idle;
                            end else begin
                                dy    <= dy + 1'b1;
                                issue <= 1'b1;
                            end
                        end else begin
                            dx    <= dx + 1'b1;
                            issue <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= drw_idle;
                end
            endcase
        end
    end

    // Stored position is the sprite centre, origin sits one pixel up-left
    always_ff @(posedge clock) begin
        if (state == drw_idle && go) begin
            id_q <= id;
        end
        if (state == drw_load && cmd_done) begin
            if (cur_field == ant_pkg::field_x) begin
                org_x <= result[`ANT_X_WIDTH-1:0] - `ANT_X_WIDTH'd1;
            end else begin
                org_y <= result[`ANT_Y_WIDTH-1:0] - `ANT_Y_WIDTH'd1;
            end
        end
    end

    always_comb begin
        instr = '0;
        if (state == drw_plot) begin
            instr.opcode = ant_pkg::draw;
            instr.plot   = 1'b1;
            instr.colour = `ANT_COLOUR;
            instr.px     = org_x + `ANT_X_WIDTH'(dx);
            instr.py     = org_y + `ANT_Y_WIDTH'(dy);
        end else begin
            instr.opcode = ant_pkg::mem_read;
            instr.id     = id_q;
            instr.field  = cur_field;
        end
    end

    dp_request_issuer u_issuer (
        .clock       (clock),
        .resetn      (resetn),
        .issue       (issue),
        .instr       (instr),
        .finished_dp (finished_dp),
        .result_dp   (result_dp),
        .dp          (dp),
        .cmd_done    (cmd_done),
        .result      (result)
    );

endmodule

// File: source/ant_update_ctrl.sv
`include "ant_params.svh"

module ant_update_ctrl (
    input  logic                            clock,
    input  logic                            resetn,
    input  logic                            go,
    input  logic [`ANT_MEM_ADDR_WIDTH-1:0]  id,
    input  ant_pkg::move_t                  move,
    input  logic                            finished_dp,
    input  logic [`ANT_RESULT_WIDTH-1:0]    result_dp,
    output ant_pkg::dp_req_t                dp,
    output logic                            phase_done
);

    // Clamp limits keep the whole sprite on screen
    localparam logic [`ANT_X_WIDTH-1:0] x_min = `ANT_X_WIDTH'(`ANT_SPRITE_W / 2);
    localparam logic [`ANT_X_WIDTH-1:0] x_max =
        `ANT_X_WIDTH'(`ANT_SCREEN_W - `ANT_SPRITE_W / 2 - 1);
    localparam logic [`ANT_Y_WIDTH-1:0] y_min = `ANT_Y_WIDTH'(`ANT_SPRITE_H / 2);
    localparam logic [`ANT_Y_WIDTH-1:0] y_max =
        `ANT_Y_WIDTH'(`ANT_SCREEN_H - `ANT_SPRITE_H / 2 - 1);

    typedef enum logic [1:0] {
        upd_idle,
        upd_load,
        upd_move,
        upd_store
    } upd_state_t;

    upd_state_t                      state;
    ant_pkg::ant_field_t             cur_field;
    logic                            issue;
    logic                            cmd_done;
    logic [`ANT_RESULT_WIDTH-1:0]    result;
    ant_pkg::dp_instr_t              instr;

    logic [`ANT_MEM_ADDR_WIDTH-1:0]  id_q;
    ant_pkg::move_t                  move_q;
    logic [`ANT_X_WIDTH-1:0]         x_q;
    logic [`ANT_Y_WIDTH-1:0]         y_q;
    logic [`ANT_FITNESS_WIDTH-1:0]   fitness_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state      <= upd_idle;
            cur_field  <= ant_pkg::field_x;
            issue      <= 1'b0;
            phase_done <= 1'b0;
        end else begin
            issue      <= 1'b0;
            phase_done <= 1'b0;
            case (state)
                upd_idle: begin
                    if (go) begin
                        cur_field <= ant_pkg::field_x;
                        issue     <= 1'b1;
                        state     <= upd_load;
                    end
                end
                upd_load: begin
                    if (cmd_done) begin
                        case (cur_field)
                            ant_pkg::field_x: begin
                                cur_field <= ant_pkg::field_y;
                                issue     <= 1'b1;
                            end
                            ant_pkg::field_y: begin
                                cur_field <= ant_pkg::field_fitness;
                                issue     <= 1'b1;
                            end
                            default: begin
                                state <= upd_move;
                            end
                        endcase
                    end
                end
                upd_move: begin
                    // Write-back starts once the new position is settled
                    cur_field <= ant_pkg::field_x;
                    issue     <= 1'b1;
                    state     <= upd_store;
                end
                upd_store: begin
                    if (cmd_done) begin
                        case (cur_field)
                            ant_pkg::field_x: begin
                                cur_field <= ant_pkg::field_y;
                                issue     <= 1'b1;
                            end
                            ant_pkg::field_y: begin
                                cur_field <= ant_pkg::field_fitness;
                                issue     <= 1'b1;
                            end
                            default: begin
                                phase_done <= 1'b1;
                                state      <= upd_idle;
                            end
                        endcase
                    end
                end
                default: begin
                    state <= upd_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == upd_idle && go) begin
            id_q   <= id;
            move_q <= move;
        end
        if (state == upd_load && cmd_done) begin
            case (cur_field)
                ant_pkg::field_x: x_q <= result[`ANT_X_WIDTH-1:0];
                ant_pkg::field_y: y_q <= result[`ANT_Y_WIDTH-1:0];
                default: fitness_q <= result[`ANT_FITNESS_WIDTH-1:0];
            endcase
        end
        if (state == upd_move) begin
            // Left beats right and up beats down
            if (move_q.left && x_q > x_min) begin
                x_q <= x_q - `ANT_X_WIDTH'd1;
            end else if (move_q.right && x_q < x_max) begin
                x_q <= x_q + `ANT_X_WIDTH'd1;
            end
            if (move_q.up && y_q > y_min) begin
                y_q <= y_q - `ANT_Y_WIDTH'd1;
            end else if (move_q.down && y_q < y_max) begin
                y_q <= y_q + `ANT_Y_WIDTH'd1;
            end
        end
    end

    // Reads before the move, writes after it
    always_comb begin
        instr        = '0;
        instr.id     = id_q;
        instr.field  = cur_field;
        instr.opcode = (state == upd_store) ? ant_pkg::mem_write : ant_pkg::mem_read;
        if (state == upd_store) begin
            case (cur_field)
                ant_pkg::field_x: instr.wdata = `ANT_RESULT_WIDTH'(x_q);
                ant_pkg::field_y: instr.wdata = `ANT_RESULT_WIDTH'(y_q);
                default: instr.wdata = `ANT_RESULT_WIDTH'(fitness_q);
            endcase
        end
    end

    dp_request_issuer u_issuer (
        .clock       (clock),
        .resetn      (resetn),
        .issue       (issue),
        .instr       (instr),
        .finished_dp (finished_dp),
        .result_dp   (result_dp),
        .dp          (dp),
        .cmd_done    (cmd_done),
        .result      (result)
    );

endmodule

// File: source/dp_request_issuer.sv
`include "ant_params.svh"

module dp_request_issuer (
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          issue,
    input  ant_pkg::dp_instr_t            instr,
    input  logic                          finished_dp,
    input  logic [`ANT_RESULT_WIDTH-1:0]  result_dp,
    output ant_pkg::dp_req_t              dp,
    output logic                          cmd_done,
    output logic [`ANT_RESULT_WIDTH-1:0]  result
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_hold,
        st_wait
    } issue_state_t;

    issue_state_t       state;
    ant_pkg::dp_instr_t instr_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state    <= st_idle;
            instr_q  <= '0;
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= 1'b0;
            case (state)
                st_idle: begin
                    if (issue) begin
                        // Command is held here until completion
                        instr_q <= instr;
                        state   <= st_start;
                    end
                end
                st_start: begin
                    state <= st_hold;
                end
                st_hold: begin
                    state <= st_wait;
                end
                st_wait: begin
                    // First cycle with start low and finished high
                    if (finished_dp) begin
                        cmd_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == st_wait && finished_dp) begin
            result <= result_dp;
        end
    end

    // Start strobe covers exactly the two cycles after issue
    always_comb begin
        dp.start = (state == st_start) || (state == st_hold);
        dp.instr = instr_q;
    end

endmodule

// File: source/ant_pkg.sv
`include "ant_params.svh"

package ant_pkg;

    // Datapath operations
    typedef enum logic [1:0] {
        mem_read  = 2'd0,
        mem_write = 2'd1,
        draw      = 2'd2
    } dp_opcode_t;

    // Words of one ant record, low part of the memory address
    typedef enum logic [1:0] {
        field_x       = 2'd0,
        field_y       = 2'd1,
        field_fitness = 2'd2
    } ant_field_t;

    // One datapath command; unused fields stay zero
    typedef struct packed {
        dp_opcode_t                      opcode;
        logic [`ANT_MEM_ADDR_WIDTH-1:0]  id;
        ant_field_t                      field;
        logic [`ANT_RESULT_WIDTH-1:0]    wdata;
        logic                            plot;
        logic [`ANT_COLOUR_WIDTH-1:0]    colour;
        logic [`ANT_X_WIDTH-1:0]         px;
        logic [`ANT_Y_WIDTH-1:0]         py;
    } dp_instr_t;

    // Request side of the datapath port
    typedef struct packed {
        logic      start;
        dp_instr_t instr;
    } dp_req_t;

    // Direction request for one step
    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
    } move_t;

endpackage

// File: include/ant_params.svh
`ifndef ANT_PARAMS_SVH
`define ANT_PARAMS_SVH

// Ant record addressing and word widths
`define ANT_MEM_ADDR_WIDTH 8
`define ANT_X_WIDTH 8
`define ANT_Y_WIDTH 7
`define ANT_FITNESS_WIDTH 8
`define ANT_RESULT_WIDTH 16

// Pixel colour, 3-bit RGB
`define ANT_COLOUR_WIDTH 3

// Sprite size in pixels
`define ANT_SPRITE_W 4
`define ANT_SPRITE_H 4

// Visible screen area
`define ANT_SCREEN_W 160
`define ANT_SCREEN_H 120

// Every ant pixel uses this colour
`define ANT_COLOUR 3'b110

`endif
